/* include/ppu_config.svh */
`ifndef PPU_CONFIG_SVH
`define PPU_CONFIG_SVH

// ====================
// Memory depths in bytes
// ====================
`define PPU_VRAM_LEN 8192
`define PPU_OAM_LEN 160

// ====================
// CPU address windows
// ====================
`define PPU_VRAM_START 16'h8000
`define PPU_VRAM_END 16'h9FFF
`define PPU_OAM_START 16'hFE00
`define PPU_OAM_END 16'hFE9F
`define PPU_REG_START 16'hFF40
`define PPU_REG_END 16'hFF4B
// OAM DMA lives outside this block
`define PPU_DMA_ADDR 16'hFF46

// Individual LCD registers
`define PPU_ADDR_LCDC 16'hFF40
`define PPU_ADDR_STAT 16'hFF41
`define PPU_ADDR_SCY 16'hFF42
`define PPU_ADDR_SCX 16'hFF43
`define PPU_ADDR_LY 16'hFF44
`define PPU_ADDR_LYC 16'hFF45
`define PPU_ADDR_BGP 16'hFF47
`define PPU_ADDR_WY 16'hFF4A
`define PPU_ADDR_WX 16'hFF4B

// ====================
// Line and frame geometry
// ====================
`define PPU_DOTS_PER_LINE 456
`define PPU_LINES_PER_FRAME 154
`define PPU_SCREEN_HEIGHT 144
`define PPU_MODE2_LEN 80
// Stand-in for the renderer's line_done
`define PPU_MODE3_LEN 172
`define PPU_MAX_SPRITES 10

`endif

/* hw/ppu_pkg.sv */
`default_nettype none

package ppu_pkg;

  // CPU byte bus
  typedef logic [15:0] bus_addr_t;
  typedef logic [7:0] byte_t;

  // Dot within a line, 0 to 455
  typedef logic [8:0] dot_t;

  // Line number as seen in LY
  typedef logic [7:0] line_t;

  // Byte offset into OAM, 0 to 159
  typedef logic [7:0] oam_idx_t;

  // Slot in the found-sprite list
  typedef logic [3:0] sprite_slot_t;

  // Encodings match the STAT mode field
  typedef enum logic [1:0] {
    HBLANK   = 2'd0,
    VBLANK   = 2'd1,
    OAM_SCAN = 2'd2,
    TRANSFER = 2'd3
  } ppu_mode_t;

endpackage

`default_nettype wire

/* hw/ppu_timing.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ppu_config.svh"

module ppu_timing (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              lcd_en,
  output ppu_pkg::ppu_mode_t     mode,
  output ppu_pkg::dot_t          dot,
  output ppu_pkg::line_t         ly,
  output logic                   vblank_req
);

  import ppu_pkg::*;

  // Last dot of the current line
  logic line_end;
  assign line_end = (dot == dot_t'(`PPU_DOTS_PER_LINE - 1));

  // ====================
  // Dot and line counters
  // ====================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot        <= '0;
      ly         <= '0;
      vblank_req <= 1'b0;
    end else begin
      vblank_req <= 1'b0;
      if (!lcd_en) begin
        // LCD off parks the counters at the frame start
        dot <= '0;
        ly  <= '0;
      end else if (line_end) begin
        dot <= '0;
        if (ly == line_t'(`PPU_LINES_PER_FRAME - 1)) begin
          ly <= '0;
        end else begin
          ly <= ly + 1'b1;
        end
        // Entering line 144
        if (ly == line_t'(`PPU_SCREEN_HEIGHT - 1)) begin
          vblank_req <= 1'b1;
        end
      end else begin
        dot <= dot + 1'b1;
      end
    end
  end

  // ====================
  // Mode FSM
  // ====================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode <= OAM_SCAN;
    end else if (!lcd_en) begin
      mode <= OAM_SCAN;
    end else begin
      case (mode)
        OAM_SCAN: begin
          if (dot == dot_t'(`PPU_MODE2_LEN - 1)) begin
            mode <= TRANSFER;
          end
        end
        // Fixed length, no renderer to end it early
        TRANSFER: begin
          if (dot == dot_t'(`PPU_MODE2_LEN + `PPU_MODE3_LEN - 1)) begin
            mode <= HBLANK;
          end
        end
        HBLANK: begin
          if (line_end) begin
            if (ly == line_t'(`PPU_SCREEN_HEIGHT - 1)) begin
              mode <= VBLANK;
            end else begin
              mode <= OAM_SCAN;
            end
          end
        end
        VBLANK: begin
          // Wrap to the next frame
          if (line_end && ly == line_t'(`PPU_LINES_PER_FRAME - 1)) begin
            mode <= OAM_SCAN;
          end
        end
        default: mode <= OAM_SCAN;
      endcase
    end
  end

  // No pixel transfer on the blanked lines
  a_no_transfer_in_vblank: assert property (@(posedge clk) disable iff (reset)
    (ly >= line_t'(`PPU_SCREEN_HEIGHT)) |-> (mode != TRANSFER))
    else $error("TRANSFER on line %0d", ly);

  a_dot_in_range: assert property (@(posedge clk) disable iff (reset)
    dot <= dot_t'(`PPU_DOTS_PER_LINE - 1))
    else $error("dot out of range %0d", dot);

endmodule

`default_nettype wire

/* hw/ppu_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ppu_config.svh"

module ppu_mem (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire ppu_pkg::bus_addr_t addr,
  input  wire ppu_pkg::byte_t     wdata,
  input  wire logic               write_en,
  input  wire logic               read_en,
  input  wire ppu_pkg::ppu_mode_t mode,
  output logic                    mem_hit,
  output ppu_pkg::byte_t          mem_rdata,
  input  wire ppu_pkg::oam_idx_t  oam_addr,
  output ppu_pkg::byte_t          oam_rdata
);

  import ppu_pkg::*;

  localparam int VRAM_AW = $clog2(`PPU_VRAM_LEN);

  byte_t vram [`PPU_VRAM_LEN];
  byte_t oam [`PPU_OAM_LEN];

  // Window decode
  logic vram_sel;
  logic oam_sel;
  logic [VRAM_AW-1:0] vram_idx;
  oam_idx_t oam_idx;

  assign vram_sel = (addr >= `PPU_VRAM_START) && (addr <= `PPU_VRAM_END);
  assign oam_sel  = (addr >= `PPU_OAM_START) && (addr <= `PPU_OAM_END);
  assign vram_idx = VRAM_AW'(addr - `PPU_VRAM_START);
  assign oam_idx  = oam_idx_t'(addr - `PPU_OAM_START);

  // CPU writes, VRAM locked out during pixel transfer
  always_ff @(posedge clk) begin
    if (write_en && vram_sel && mode != TRANSFER) begin
      vram[vram_idx] <= wdata;
    end
    if (write_en && oam_sel) begin
      oam[oam_idx] <= wdata;
    end
  end

  // CPU read side
  assign mem_hit = read_en && (vram_sel || oam_sel);

  always_comb begin
    mem_rdata = 8'hFF;
    if (vram_sel && mode != TRANSFER) begin
      mem_rdata = vram[vram_idx];
    end
    if (oam_sel) begin
      mem_rdata = oam[oam_idx];
    end
  end

  // Scan port, always open
  assign oam_rdata = oam[oam_addr];

  // Scan addresses come from another block
  a_oam_addr_in_range: assert property (@(posedge clk) disable iff (reset)
    oam_addr < oam_idx_t'(`PPU_OAM_LEN))
    else $error("scan OAM address %0d out of range", oam_addr);

endmodule

`default_nettype wire

/* hw/ppu_oam_scan.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ppu_config.svh"

module ppu_oam_scan (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire ppu_pkg::ppu_mode_t    mode,
  input  wire ppu_pkg::dot_t         dot,
  input  wire ppu_pkg::line_t        ly,
  input  wire logic                  tall_sprites,
  output ppu_pkg::oam_idx_t          oam_addr,
  input  wire ppu_pkg::byte_t        oam_rdata,
  input  wire ppu_pkg::sprite_slot_t sprite_sel,
  output ppu_pkg::sprite_slot_t      sprite_count,
  output ppu_pkg::byte_t             sprite_y,
  output ppu_pkg::byte_t             sprite_x,
  output ppu_pkg::byte_t             sprite_tile,
  output ppu_pkg::byte_t             sprite_attr
);

  import ppu_pkg::*;

  localparam int MAX = `PPU_MAX_SPRITES;

  // Found list payload
  logic [5:0] slot_entry [MAX];
  byte_t slot_y [MAX];
  byte_t slot_x [MAX];
  byte_t slot_tile [MAX];
  byte_t slot_attr [MAX];

  logic [5:0] entry;
  logic [4:0] height;
  logic [8:0] ly_off;
  logic [8:0] y_end;
  logic in_range;
  logic add_now;
  logic x_pending;
  sprite_slot_t base_count;
  dot_t fill_dot;
  sprite_slot_t fill_slot;
  logic fill_now;
  logic sel_ok;

  // ====================
  // Y check, entry n on dot 2n
  // ====================
  assign entry  = dot[6:1];
  assign height = tall_sprites ? 5'd16 : 5'd8;
  assign ly_off = {1'b0, ly} + 9'd16;
  assign y_end  = {1'b0, oam_rdata} + {4'b0, height};
  assign in_range = (ly_off >= {1'b0, oam_rdata}) && (ly_off < y_end);

  // List restarts at dot 0
  assign base_count = (dot == '0) ? '0 : sprite_count;
  assign add_now = (mode == OAM_SCAN) && !dot[0] && in_range &&
                   (base_count < sprite_slot_t'(MAX));

  // Tile and attribute bytes of found slots, two dots per slot
  // in the first dots of TRANSFER while the port is otherwise idle
  assign fill_dot  = dot - dot_t'(`PPU_MODE2_LEN);
  assign fill_slot = sprite_slot_t'(fill_dot[8:1]);
  assign fill_now  = (mode == TRANSFER) && (fill_dot < dot_t'(2 * MAX)) &&
                     (fill_slot < sprite_count);

  always_comb begin
    oam_addr = '0;
    if (mode == OAM_SCAN) begin
      // Even dot Y, odd dot X
      oam_addr = {entry, 1'b0, dot[0]};
    end else if (fill_now) begin
      oam_addr = {slot_entry[fill_slot], 1'b1, dot[0]};
    end
  end

  // Count and X follow-up flag
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sprite_count <= '0;
      x_pending    <= 1'b0;
    end else begin
      x_pending <= add_now;
      if (add_now) begin
        sprite_count <= base_count + 1'b1;
      end else if (dot == '0) begin
        sprite_count <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (add_now) begin
      slot_y[base_count]     <= oam_rdata;
      slot_entry[base_count] <= entry;
    end
    // X of the entry kept on the previous dot
    if (x_pending) begin
      slot_x[sprite_count - 1'b1] <= oam_rdata;
    end
    if (fill_now && !dot[0]) begin
      slot_tile[fill_slot] <= oam_rdata;
    end
    if (fill_now && dot[0]) begin
      slot_attr[fill_slot] <= oam_rdata;
    end
  end

  // ====================
  // Sprite read port
  // ====================
  assign sel_ok      = sprite_sel < sprite_slot_t'(MAX);
  assign sprite_y    = sel_ok ? slot_y[sprite_sel] : '0;
  assign sprite_x    = sel_ok ? slot_x[sprite_sel] : '0;
  assign sprite_tile = sel_ok ? slot_tile[sprite_sel] : '0;
  assign sprite_attr = sel_ok ? slot_attr[sprite_sel] : '0;

  a_count_limit: assert property (@(posedge clk) disable iff (reset)
    sprite_count <= sprite_slot_t'(MAX))
    else $error("sprite_count %0d over limit", sprite_count);

endmodule

`default_nettype wire

/* hw/ppu_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ppu_config.svh"

module ppu_regs (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire ppu_pkg::bus_addr_t addr,
  input  wire ppu_pkg::byte_t     wdata,
  input  wire logic               write_en,
  input  wire logic               read_en,
  input  wire logic               mem_hit,
  input  wire ppu_pkg::byte_t     mem_rdata,
  input  wire ppu_pkg::ppu_mode_t mode,
  input  wire ppu_pkg::line_t     ly,
  output ppu_pkg::byte_t          rdata,
  output logic                    lcd_en,
  output logic                    tall_sprites,
  output logic                    stat_req
);

  import ppu_pkg::*;

  // LCD register file
  byte_t lcdc;
  logic [3:0] stat_en;
  byte_t scy;
  byte_t scx;
  byte_t lyc;
  byte_t bgp;
  byte_t wy;
  byte_t wx;

  logic reg_sel;
  logic lyc_eq;
  line_t ly_prev;
  ppu_mode_t mode_prev;
  logic lyc_event;
  logic mode_event;

  // DMA address sits inside the window but belongs elsewhere
  assign reg_sel = (addr >= `PPU_REG_START) && (addr <= `PPU_REG_END) &&
                   (addr != `PPU_DMA_ADDR);

  assign lyc_eq       = (ly == lyc);
  assign lcd_en       = lcdc[7];
  assign tall_sprites = lcdc[2];

  // ====================
  // Register writes
  // ====================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lcdc    <= '0;
      stat_en <= '0;
      scy     <= '0;
      scx     <= '0;
      lyc     <= '0;
      bgp     <= '0;
      wy      <= '0;
      wx      <= '0;
    end else if (write_en && reg_sel) begin
      case (addr)
        `PPU_ADDR_LCDC: lcdc <= wdata;
        // Only the interrupt enables
        `PPU_ADDR_STAT: stat_en <= wdata[6:3];
        `PPU_ADDR_SCY:  scy <= wdata;
        `PPU_ADDR_SCX:  scx <= wdata;
        `PPU_ADDR_LYC:  lyc <= wdata;
        `PPU_ADDR_BGP:  bgp <= wdata;
        `PPU_ADDR_WY:   wy <= wdata;
        `PPU_ADDR_WX:   wx <= wdata;
        // LY is read only
        default: ;
      endcase
    end
  end

  // ====================
  // CPU read mux
  // ====================
  always_comb begin
    rdata = 8'hFF;
    if (mem_hit) begin
      rdata = mem_rdata;
    end else if (read_en && reg_sel) begin
      case (addr)
        `PPU_ADDR_LCDC: rdata = lcdc;
        `PPU_ADDR_STAT: rdata = {1'b1, stat_en, lyc_eq, mode};
        `PPU_ADDR_SCY:  rdata = scy;
        `PPU_ADDR_SCX:  rdata = scx;
        `PPU_ADDR_LY:   rdata = ly;
        `PPU_ADDR_LYC:  rdata = lyc;
        `PPU_ADDR_BGP:  rdata = bgp;
        `PPU_ADDR_WY:   rdata = wy;
        `PPU_ADDR_WX:   rdata = wx;
        default:        rdata = 8'hFF;
      endcase
    end
  end

  // ====================
  // STAT interrupt
  // ====================
  // Edges seen against last cycle's LY and mode
  assign lyc_event = stat_en[3] && (ly != ly_prev) && lyc_eq;

  always_comb begin
    mode_event = 1'b0;
    if (mode != mode_prev) begin
      case (mode)
        OAM_SCAN: mode_event = stat_en[2];
        VBLANK:   mode_event = stat_en[1];
        HBLANK:   mode_event = stat_en[0];
        default:  mode_event = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ly_prev   <= '0;
      mode_prev <= OAM_SCAN;
      stat_req  <= 1'b0;
    end else begin
      ly_prev   <= ly;
      mode_prev <= mode;
      // Silent while the LCD is off
      stat_req  <= lcd_en && (lyc_event || mode_event);
    end
  end

endmodule

`default_nettype wire

/* hw/ppu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_top (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire ppu_pkg::bus_addr_t    addr,
  input  wire ppu_pkg::byte_t        wdata,
  input  wire logic                  write_en,
  input  wire logic                  read_en,
  output ppu_pkg::byte_t             rdata,
  output logic                       vblank_req,
  output logic                       stat_req,
  input  wire ppu_pkg::sprite_slot_t sprite_sel,
  output ppu_pkg::sprite_slot_t      sprite_count,
  output ppu_pkg::byte_t             sprite_y,
  output ppu_pkg::byte_t             sprite_x,
  output ppu_pkg::byte_t             sprite_tile,
  output ppu_pkg::byte_t             sprite_attr
);

  import ppu_pkg::*;

  // Shared timing
  ppu_mode_t mode;
  dot_t dot;
  line_t ly;

  // Control from the register file
  logic lcd_en;
  logic tall_sprites;

  // Memory to read mux and scan
  logic mem_hit;
  byte_t mem_rdata;
  oam_idx_t oam_addr;
  byte_t oam_rdata;

  ppu_timing timing0 (
    .clk        (clk),
    .reset      (reset),
    .lcd_en     (lcd_en),
    .mode       (mode),
    .dot        (dot),
    .ly         (ly),
    .vblank_req (vblank_req)
  );

  ppu_mem mem0 (
    .clk       (clk),
    .reset     (reset),
    .addr      (addr),
    .wdata     (wdata),
    .write_en  (write_en),
    .read_en   (read_en),
    .mode      (mode),
    .mem_hit   (mem_hit),
    .mem_rdata (mem_rdata),
    .oam_addr  (oam_addr),
    .oam_rdata (oam_rdata)
  );

  ppu_oam_scan scan0 (
    .clk          (clk),
    .reset        (reset),
    .mode         (mode),
    .dot          (dot),
    .ly           (ly),
    .tall_sprites (tall_sprites),
    .oam_addr     (oam_addr),
    .oam_rdata    (oam_rdata),
    .sprite_sel   (sprite_sel),
    .sprite_count (sprite_count),
    .sprite_y     (sprite_y),
    .sprite_x     (sprite_x),
    .sprite_tile  (sprite_tile),
    .sprite_attr  (sprite_attr)
  );

  ppu_regs regs0 (
    .clk          (clk),
    .reset        (reset),
    .addr         (addr),
    .wdata        (wdata),
    .write_en     (write_en),
    .read_en      (read_en),
    .mem_hit      (mem_hit),
    .mem_rdata    (mem_rdata),
    .mode         (mode),
    .ly           (ly),
    .rdata        (rdata),
    .lcd_en       (lcd_en),
    .tall_sprites (tall_sprites),
    .stat_req     (stat_req)
  );

endmodule

`default_nettype wire

/* verif/ppu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ppu_config.svh"

module ppu_tb;

  import ppu_pkg::*;

  // Longest wait is a bit under one frame
  localparam int WAIT_LIMIT = 200000;

  // ====================
  // DUT signals
  // ====================
  logic clk;
  logic reset;
  bus_addr_t addr;
  byte_t wdata;
  logic write_en;
  logic read_en;
  byte_t rdata;
  logic vblank_req;
  logic stat_req;
  sprite_slot_t sprite_sel;
  sprite_slot_t sprite_count;
  byte_t sprite_y;
  byte_t sprite_x;
  byte_t sprite_tile;
  byte_t sprite_attr;

  // Score and interrupt bookkeeping
  int errors;
  int checks;
  int pulse_errors;
  int vblank_seen;
  int stat_seen;
  logic vblank_last;
  logic stat_last;

  ppu_top dut0 (
    .clk          (clk),
    .reset        (reset),
    .addr         (addr),
    .wdata        (wdata),
    .write_en     (write_en),
    .read_en      (read_en),
    .rdata        (rdata),
    .vblank_req   (vblank_req),
    .stat_req     (stat_req),
    .sprite_sel   (sprite_sel),
    .sprite_count (sprite_count),
    .sprite_y     (sprite_y),
    .sprite_x     (sprite_x),
    .sprite_tile  (sprite_tile),
    .sprite_attr  (sprite_attr)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // Count request pulses, each must last one cycle
  always @(posedge clk) begin
    if (reset) begin
      vblank_seen  <= 0;
      stat_seen    <= 0;
      vblank_last  <= 1'b0;
      stat_last    <= 1'b0;
      pulse_errors <= 0;
    end else begin
      vblank_last <= vblank_req;
      stat_last   <= stat_req;
      if (vblank_req) begin
        vblank_seen <= vblank_seen + 1;
      end
      if (stat_req) begin
        stat_seen <= stat_seen + 1;
      end
      if ((vblank_req && vblank_last) || (stat_req && stat_last)) begin
        pulse_errors <= pulse_errors + 1;
        $display("Error at %0t: interrupt request high for more than one cycle", $time);
      end
    end
  end

  // ====================
  // Reporting
  // ====================
  task automatic note_mismatch(input string what, input byte_t got, input byte_t expected);
    errors++;
    $display("[FAIL] t=%0t %s: got %02h, expected %02h", $time, what, got, expected);
  endtask

  // Timeouts and bad stimulus end the run here
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks: %0d, errors: %0d", checks, errors + pulse_errors);
    $display("RESULT: FAIL");
    $finish;
  endtask

  // ====================
  // Object byte patterns
  // ====================
  // Tile and attributes follow from X so every object differs
  function automatic byte_t tile_of(input byte_t x);
    return x ^ 8'hC3;
  endfunction

  function automatic byte_t attr_of(input byte_t x);
    return {x[3:0], x[7:4]};
  endfunction

  // LY after a given line, wrapping at the frame end
  function automatic byte_t line_after(input byte_t l);
    return (l == byte_t'(`PPU_LINES_PER_FRAME - 1)) ? 8'h00 : l + 8'h01;
  endfunction

  // ====================
  // CPU bus
  // ====================
  // Tasks start and end on a falling edge
  task automatic bus_write(input bus_addr_t a, input byte_t d);
    addr     = a;
    wdata    = d;
    write_en = 1'b1;
    @(negedge clk);
    write_en = 1'b0;
  endtask

  // Sampled midway through the low phase, rdata is combinational
  task automatic bus_read(input bus_addr_t a, output byte_t d);
    addr    = a;
    read_en = 1'b1;
    #1;
    d = rdata;
    @(negedge clk);
    read_en = 1'b0;
  endtask

  task automatic expect_read(input bus_addr_t a, input byte_t expected);
    byte_t got;
    bus_read(a, got);
    checks++;
    if (got !== expected) begin
      note_mismatch($sformatf("read %04h", a), got, expected);
    end
  endtask

  task automatic fill_bytes(input bus_addr_t start, input int n, input byte_t value);
    int i;
    for (i = 0; i < n; i++) begin
      bus_write(bus_addr_t'(start + i), value);
    end
  endtask

  // Random bytes in, then read back in order
  task automatic random_fill(input bus_addr_t start, input int n);
    byte_t fill_data[$];
    byte_t v;
    byte_t got;
    int i;
    for (i = 0; i < n; i++) begin
      v = byte_t'($urandom);
      fill_data.push_back(v);
      bus_write(bus_addr_t'(start + i), v);
    end
    for (i = 0; i < n; i++) begin
      bus_read(bus_addr_t'(start + i), got);
      checks++;
      if (got !== fill_data[i]) begin
        note_mismatch($sformatf("random fill %04h", bus_addr_t'(start + i)), got,
                      fill_data[i]);
      end
    end
  endtask

  // OAM entry is Y, X, tile, attributes
  task automatic place_object(input int idx, input byte_t y, input byte_t x);
    bus_addr_t base;
    base = bus_addr_t'(`PPU_OAM_START + idx * 4);
    bus_write(base, y);
    bus_write(base + 16'd1, x);
    bus_write(base + 16'd2, tile_of(x));
    bus_write(base + 16'd3, attr_of(x));
  endtask

  // ====================
  // Waits
  // ====================
  // LY may only hold or step by one on the way
  task automatic wait_ly(input byte_t target);
    byte_t v;
    byte_t prev;
    int n;
    bit found;
    found = 1'b0;
    prev = '0;
    n = 0;
    while (!found && n < WAIT_LIMIT) begin
      bus_read(`PPU_ADDR_LY, v);
      checks++;
      if (n > 0 && v !== prev && v !== line_after(prev)) begin
        errors++;
        $display("[FAIL] t=%0t LY stepped from %02h to %02h", $time, prev, v);
      end
      prev = v;
      found = (v === target);
      n++;
    end
    if (!found) begin
      abort_run($sformatf("Timed out waiting for LY to reach %0d", target));
    end
  endtask

  // Mode from the low two STAT bits
  task automatic wait_mode(input logic [1:0] target);
    byte_t v;
    int n;
    bit found;
    found = 1'b0;
    n = 0;
    while (!found && n < WAIT_LIMIT) begin
      bus_read(`PPU_ADDR_STAT, v);
      found = (v[1:0] === target);
      n++;
    end
    if (!found) begin
      abort_run($sformatf("Timed out waiting for STAT mode %0d", target));
    end
  endtask

  // Next pulse after the call
  task automatic wait_irq(input bit want_vblank);
    int start;
    int n;
    bit seen;
    start = want_vblank ? vblank_seen : stat_seen;
    seen = 1'b0;
    n = 0;
    while (!seen && n < WAIT_LIMIT) begin
      @(negedge clk);
      seen = want_vblank ? (vblank_seen > start) : (stat_seen > start);
      n++;
    end
    if (!seen) begin
      abort_run(want_vblank ? "Timed out waiting for a vblank_req pulse" :
                              "Timed out waiting for a stat_req pulse");
    end
  endtask

  // No request may pulse in this window
  task automatic watch_quiet(input int cycles);
    int v0;
    int s0;
    int n;
    v0 = vblank_seen;
    s0 = stat_seen;
    for (n = 0; n < cycles; n++) begin
      @(negedge clk);
    end
    checks++;
    if (vblank_seen != v0 || stat_seen != s0) begin
      errors++;
      $display("Error at %0t: interrupt request raised while none was expected", $time);
    end
  endtask

  // ====================
  // Sprite port
  // ====================
  task automatic check_sprite(input sprite_slot_t count, input sprite_slot_t slot,
                              input byte_t y, input byte_t x);
    sprite_sel = slot;
    #1;
    checks += 3;
    if (sprite_count !== count) begin
      note_mismatch("sprite_count", byte_t'(sprite_count), byte_t'(count));
    end
    if (sprite_y !== y) begin
      note_mismatch($sformatf("slot %0d y", slot), sprite_y, y);
    end
    if (sprite_x !== x) begin
      note_mismatch($sformatf("slot %0d x", slot), sprite_x, x);
    end
    @(negedge clk);
    // Tile and attribute bytes settle in the first dots of TRANSFER
    wait_mode(2'd0);
    #1;
    checks += 2;
    if (sprite_tile !== tile_of(x)) begin
      note_mismatch($sformatf("slot %0d tile", slot), sprite_tile, tile_of(x));
    end
    if (sprite_attr !== attr_of(x)) begin
      note_mismatch($sformatf("slot %0d attr", slot), sprite_attr, attr_of(x));
    end
    @(negedge clk);
  endtask

  // ====================
  // Stimulus interpreter
  // ====================
  task automatic run_line(input string text);
    string cmd;
    string kind;
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] a3;
    logic [31:0] a4;
    int got;
    cmd = "";
    kind = "";
    a1 = '0;
    a2 = '0;
    a3 = '0;
    a4 = '0;
    got = $sscanf(text, "%s", cmd);
    // Blank lines and comments
    if (got < 1 || cmd.getc(0) == "#") begin
      return;
    end
    if (cmd == "W") begin
      got = $sscanf(text, "%s %h %h", cmd, a1, a2);
      if (got != 3) abort_run({"Malformed stimulus line: ", text});
      bus_write(a1[15:0], a2[7:0]);
    end else if (cmd == "R") begin
      got = $sscanf(text, "%s %h %h", cmd, a1, a2);
      if (got != 3) abort_run({"Malformed stimulus line: ", text});
      expect_read(a1[15:0], a2[7:0]);
    end else if (cmd == "FILL") begin
      got = $sscanf(text, "%s %h %h %h", cmd, a1, a2, a3);
      if (got != 4) abort_run({"Malformed stimulus line: ", text});
      fill_bytes(a1[15:0], int'(a2), a3[7:0]);
    end else if (cmd == "RND") begin
      got = $sscanf(text, "%s %h %h", cmd, a1, a2);
      if (got != 3) abort_run({"Malformed stimulus line: ", text});
      random_fill(a1[15:0], int'(a2));
    end else if (cmd == "OBJ") begin
      got = $sscanf(text, "%s %h %h %h", cmd, a1, a2, a3);
      if (got != 4) abort_run({"Malformed stimulus line: ", text});
      place_object(int'(a1), a2[7:0], a3[7:0]);
    end else if (cmd == "WAITLY") begin
      got = $sscanf(text, "%s %h", cmd, a1);
      if (got != 2) abort_run({"Malformed stimulus line: ", text});
      wait_ly(a1[7:0]);
    end else if (cmd == "WAITMODE") begin
      got = $sscanf(text, "%s %h", cmd, a1);
      if (got != 2) abort_run({"Malformed stimulus line: ", text});
      wait_mode(a1[1:0]);
    end else if (cmd == "SPR") begin
      got = $sscanf(text, "%s %h %h %h %h", cmd, a1, a2, a3, a4);
      if (got != 5) abort_run({"Malformed stimulus line: ", text});
      check_sprite(a1[3:0], a2[3:0], a3[7:0], a4[7:0]);
    end else if (cmd == "IRQ") begin
      got = $sscanf(text, "%s %s %h", cmd, kind, a1);
      if (kind == "VBLANK") begin
        wait_irq(1'b1);
      end else if (kind == "STAT") begin
        wait_irq(1'b0);
      end else if (kind == "NONE" && got == 3) begin
        watch_quiet(int'(a1));
      end else begin
        abort_run({"Malformed stimulus line: ", text});
      end
    end else begin
      abort_run({"Unknown stimulus command: ", text});
    end
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    int fd;
    string text;
    clk        = 1'b0;
    reset      = 1'b1;
    addr       = '0;
    wdata      = '0;
    write_en   = 1'b0;
    read_en    = 1'b0;
    sprite_sel = '0;
    errors     = 0;
    checks     = 0;
    void'($urandom(32'h7f11));

    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    fd = $fopen("verif/ppu_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open verif/ppu_stimulus.txt");
    end else begin
      while (!$feof(fd)) begin
        text = "";
        if ($fgets(text, fd) > 0) begin
          run_line(text);
        end
      end
      $fclose(fd);

      errors += pulse_errors;
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verif/ppu_stimulus.txt */
# Columns: command, then arguments, all numbers hex
# W addr data | R addr expected | FILL addr n data | RND addr n | OBJ entry y x
# WAITLY line | WAITMODE mode | SPR count slot y x | IRQ VBLANK | IRQ STAT | IRQ NONE cycles

# Register file with the LCD off
FILL FE00 A0 00
W FF42 12
R FF42 12
W FF43 34
R FF43 34
W FF45 56
R FF45 56
W FF47 E4
R FF47 E4
W FF4A 78
R FF4A 78
W FF4B 9A
R FF4B 9A
W FF41 FF
R FF41 FA
W FF41 00
R FF41 82
W FF44 77
R FF44 00
R FF46 FF
R FF4C FF
R FEA0 FF
R 0000 FF

# VRAM and OAM access per mode
RND 8000 10
RND 9FF8 8
W FF40 80
R FF40 80
WAITMODE 0
W 8200 3C
R 8200 3C
WAITMODE 3
R 8200 FF
W 8200 99
W FE9D 5A
R FE9D 5A
WAITMODE 0
R 8200 3C
WAITMODE 2
R FE9D 5A

# LYC compare, then mode 0 interrupts
WAITLY 3
R FF44 03
W FF45 05
W FF41 40
IRQ STAT
R FF44 05
R FF41 C6
W FF41 08
IRQ STAT
R FF41 8C
IRQ STAT
R FF41 88
R FF44 06
W FF41 00

# VBlank entry and frame wrap
WAITLY 8F
IRQ VBLANK
R FF44 90
R FF41 81
WAITLY 99
WAITLY 0
R FF44 00
R FF41 82

# Sprites near line 20, LY+16 is 24
OBJ 0 24 01
OBJ 1 10 02
OBJ 2 1A 03
OBJ 3 1D 04
OBJ 4 20 05
OBJ 5 60 06
OBJ 6 1E 07
OBJ 7 22 08
OBJ 8 15 09
OBJ 9 21 0A
OBJ A 23 0B
OBJ B 1F 0C
OBJ C 24 0D
OBJ D 25 0E
OBJ E 1C 0F
OBJ F 20 10
OBJ 10 1D 11
OBJ 11 1E 12
WAITLY 14
WAITMODE 3
SPR A 0 24 01
SPR A 1 1D 04
SPR A 2 20 05
SPR A 3 1E 07
SPR A 4 22 08
SPR A 5 21 0A
SPR A 6 23 0B
SPR A 7 1F 0C
SPR A 8 24 0D
SPR A 9 20 10

# Same line with 8x16 sprites
W FF40 84
WAITLY 15
WAITLY 14
WAITMODE 3
SPR A 0 24 01
SPR A 1 1A 03
SPR A 2 1D 04
SPR A 3 20 05
SPR A 4 1E 07
SPR A 5 22 08
SPR A 6 15 09
SPR A 7 21 0A
SPR A 8 23 0B
SPR A 9 1F 0C

# LCD off mid line, all STAT sources armed
W FF45 00
W FF41 78
W FF40 00
IRQ NONE C8
R FF44 00
R FF41 FE

/* compile.f */
+incdir+include
hw/ppu_pkg.sv
hw/ppu_timing.sv
hw/ppu_mem.sv
hw/ppu_oam_scan.sv
hw/ppu_regs.sv
hw/ppu_top.sv
verif/ppu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := ppu_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
